// File: tb.f
verilog/mmio_pkg.sv
verilog/mmio_router.sv
verilog/loader_ram.sv
verilog/text_write_port.sv
verilog/trace_queue.sv
verilog/mmio_top.sv
dv/mmio_checker.sv
dv/tb_top.sv

// File: dv/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    localparam int loader_addr_bits = 10;
    localparam int text_addr_bits   = 15;
    localparam int text_wait_cycles = 5;
    localparam int trace_depth_bits = 6;
    localparam int n_accesses       = 3000;
    localparam int max_cycles       = n_accesses * 16;

    logic                        clk_pipeline = 1'b0;
    logic                        rst;
    mmio_pkg::dmem_req_t         dmem_req;
    mmio_pkg::dmem_addr_t        instr_addr;
    logic [mmio_pkg::WORD_W-1:0] dmem_rdata;
    logic [mmio_pkg::WORD_W-1:0] instr_rdata;
    logic                        mem_stall;
    mmio_pkg::ext_req_t          ext_req;
    logic                        ext_ready;
    logic [mmio_pkg::WORD_W-1:0] ext_rdata;
    logic [text_addr_bits-1:0]   text_rd_addr;
    logic [7:0]                  text_rd_char;
    int                          err_data;
    int                          err_stall;
    int                          err_text;
    int                          err_trace;
    int                          n_checks;
    logic [31:0]                 lfsr_state;
    logic                        ext_access;
    int                          wait_left;
    int                          cycle_cnt;
    int                          n;

    always #5 clk_pipeline = ~clk_pipeline;

    mmio_top #(
        .loader_addr_bits (loader_addr_bits),
        .text_addr_bits   (text_addr_bits),
        .text_wait_cycles (text_wait_cycles),
        .trace_depth_bits (trace_depth_bits)
    ) u_dut (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .dmem_req     (dmem_req),
        .instr_addr   (instr_addr),
        .dmem_rdata   (dmem_rdata),
        .instr_rdata  (instr_rdata),
        .mem_stall    (mem_stall),
        .ext_req      (ext_req),
        .ext_ready    (ext_ready),
        .ext_rdata    (ext_rdata),
        .text_rd_addr (text_rd_addr),
        .text_rd_char (text_rd_char)
    );

    mmio_checker #(
        .loader_addr_bits (loader_addr_bits),
        .text_addr_bits   (text_addr_bits),
        .text_wait_cycles (text_wait_cycles),
        .trace_depth_bits (trace_depth_bits)
    ) u_check (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .dmem_req     (dmem_req),
        .instr_addr   (instr_addr),
        .dmem_rdata   (dmem_rdata),
        .instr_rdata  (instr_rdata),
        .mem_stall    (mem_stall),
        .ext_req      (ext_req),
        .ext_ready    (ext_ready),
        .ext_rdata    (ext_rdata),
        .text_rd_addr (text_rd_addr),
        .text_rd_char (text_rd_char),
        .err_data     (err_data),
        .err_stall    (err_stall),
        .err_text     (err_text),
        .err_trace    (err_trace),
        .n_checks     (n_checks)
    );

    //////////////////////////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////////////////////////

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // cpu access driver and main memory responder
    //////////////////////////////////////////////////////////////////////

    task automatic drive_access();
        mmio_pkg::dmem_req_t req;
        logic [3:0]          region;
        logic [25:0]         offset;
        logic [3:0]          ia_region;
        logic [25:0]         ia_offset;
        logic [2:0]          kind;
        req        = '0;
        kind       = 3'(random_bits(3));
        ext_access = 1'b0;
        wait_left  = 0;
        case (kind)
            3'd0, 3'd1: begin
                // small window so reads hit earlier writes
                region      = 4'hf;
                offset      = {16'(random_bits(16)), 5'b0, 5'(random_bits(5))};
                req.read    = (kind == 3'd0);
                req.write   = (kind == 3'd1);
                req.wdata   = random_bits(32);
                req.byte_en = 4'(random_bits(4));
            end
            3'd2: begin
                region      = 4'hc;
                offset      = {13'(random_bits(13)), 9'b0, 4'(random_bits(4))};
                req.write   = 1'b1;
                req.wdata   = random_bits(32);
                req.byte_en = random_bits(1) ? 4'b0001 << random_bits(2) : 4'(random_bits(4));
            end
            3'd3: begin
                region = 4'hd;
                case (2'(random_bits(2)))
                    2'd0:    offset = mmio_pkg::TRACE_START_SEL;
                    2'd1:    offset = mmio_pkg::TRACE_END_SEL;
                    default: offset = {18'(random_bits(18)), 8'(random_bits(8))};
                endcase
                req.read = 1'b1;
            end
            3'd4, 3'd5: begin
                // regions 0 to A with ready held low for 0 to 7 cycles
                region      = 4'(random_bits(4) % 11);
                offset      = 26'(random_bits(26));
                req.read    = (kind == 3'd4);
                req.write   = (kind == 3'd5);
                req.wdata   = random_bits(32);
                req.byte_en = 4'(random_bits(4));
                ext_access  = 1'b1;
                wait_left   = random_bits(3);
            end
            3'd6: begin
                region   = random_bits(1) ? 4'hb : 4'he;
                offset   = 26'(random_bits(26));
                req.read = 1'b1;
            end
            default: begin
                // idle data side with only the fetch below
                region = 4'(random_bits(4));
                offset = 26'(random_bits(26));
            end
        endcase
        req.addr  = {region, offset};
        ia_region = random_bits(1) ? 4'hf : 4'(random_bits(4));
        ia_offset = {16'(random_bits(16)), 5'b0, 5'(random_bits(5))};
        dmem_req     <= req;
        instr_addr   <= {ia_region, ia_offset};
        text_rd_addr <= text_addr_bits'(random_bits(6));
        ext_rdata    <= random_bits(32);
        ext_ready    <= ext_access ? (wait_left == 0) : 1'(random_bits(1));
    endtask

    // access completes on the first rising edge without a stall
    task automatic wait_for_completion();
        @(posedge clk_pipeline);
        while (mem_stall) begin
            @(negedge clk_pipeline);
            if (ext_access) begin
                if (wait_left > 0) begin
                    wait_left--;
                end
                ext_ready <= (wait_left == 0);
            end
            @(posedge clk_pipeline);
        end
    endtask

    initial begin
        rst          = 1'b0;
        dmem_req     = '0;
        instr_addr   = '0;
        ext_ready    = 1'b0;
        ext_rdata    = '0;
        text_rd_addr = '0;
        lfsr_state   = 32'hc8ceacbb;
        repeat (8) @(posedge clk_pipeline);
        @(negedge clk_pipeline);
        rst <= 1'b1;
        for (n = 0; n < n_accesses; n++) begin
            @(negedge clk_pipeline);
            drive_access();
            wait_for_completion();
        end
        @(negedge clk_pipeline);
        dmem_req  <= '0;
        ext_ready <= 1'b0;
        repeat (4) @(posedge clk_pipeline);
        $display("checks %0d, errors data %0d stall %0d text %0d trace %0d",
                 n_checks, err_data, err_stall, err_text, err_trace);
        if (err_data + err_stall + err_text + err_trace == 0 && n_checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // cycle budget for the whole run
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk_pipeline);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: dv/mmio_checker.sv
`timescale 1ns/1ns

module mmio_checker #(
    parameter int loader_addr_bits = 10,
    parameter int text_addr_bits   = 15,
    parameter int text_wait_cycles = 5,
    parameter int trace_depth_bits = 6
) (
    input  logic                        clk_pipeline,
    input  logic                        rst,
    input  mmio_pkg::dmem_req_t         dmem_req,
    input  mmio_pkg::dmem_addr_t        instr_addr,
    input  logic [mmio_pkg::WORD_W-1:0] dmem_rdata,
    input  logic [mmio_pkg::WORD_W-1:0] instr_rdata,
    input  logic                        mem_stall,
    input  mmio_pkg::ext_req_t          ext_req,
    input  logic                        ext_ready,
    input  logic [mmio_pkg::WORD_W-1:0] ext_rdata,
    input  logic [text_addr_bits-1:0]   text_rd_addr,
    input  logic [7:0]                  text_rd_char,
    output int                          err_data,
    output int                          err_stall,
    output int                          err_text,
    output int                          err_trace,
    output int                          n_checks
);

    localparam int ldr_depth = 1 << loader_addr_bits;
    localparam int txt_depth = 1 << text_addr_bits;
    localparam int trc_depth = 1 << trace_depth_bits;

    // models with known flags for the undefined RAM contents
    logic [31:0] ldr_mem   [0:ldr_depth-1];
    logic [3:0]  ldr_known [0:ldr_depth-1];
    logic [7:0]  txt_mem   [0:txt_depth-1];
    logic        txt_known [0:txt_depth-1];
    logic [31:0] trc_mem   [0:trc_depth-1][0:3];
    logic        trc_known [0:trc_depth-1];
    int          trc_start;
    int          trc_end;
    logic        trc_in_run;
    int          text_cnt;

    initial begin
        int i;
        err_data  = 0;
        err_stall = 0;
        err_text  = 0;
        err_trace = 0;
        n_checks  = 0;
        for (i = 0; i < ldr_depth; i++) begin
            ldr_known[i] = 4'b0000;
        end
        for (i = 0; i < txt_depth; i++) begin
            txt_known[i] = 1'b0;
        end
        for (i = 0; i < trc_depth; i++) begin
            trc_known[i] = 1'b0;
        end
    end

    function automatic logic [31:0] byte_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // kind 0 data, 1 stall, 2 text, 3 trace
    task automatic compare_word(input int kind, input string what, input logic [31:0] got,
                                input logic [31:0] exp, input logic [31:0] mask);
        n_checks++;
        if ((got & mask) !== (exp & mask)) begin
            $display("ERR %0t %s: got %h expected %h", $time, what, got & mask, exp & mask);
            case (kind)
                0:       err_data++;
                1:       err_stall++;
                2:       err_text++;
                default: err_trace++;
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare on the pre-edge values and then advance the models
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_pipeline) begin : check_cycle
        logic [3:0]  region;
        logic [25:0] off;
        logic [25:0] ioff;
        logic        rd;
        logic        wr;
        logic        exp_valid;
        logic        exp_stall;
        logic [1:0]  lane;
        logic [7:0]  chr;
        int          lidx;
        int          iidx;
        int          tidx;
        int          cidx;
        int          i;
        region    = dmem_req.addr.region;
        off       = dmem_req.addr.offset;
        ioff      = instr_addr.offset;
        rd        = dmem_req.read;
        wr        = dmem_req.write;
        exp_valid = (region <= 4'ha) && (rd || wr);
        lidx      = int'(off[loader_addr_bits-1:0]);
        iidx      = int'(ioff[loader_addr_bits-1:0]);
        tidx      = int'(off[7:2]) % trc_depth;
        if (!rst) begin
            compare_word(1, "mem_stall in reset", 32'(mem_stall), 32'h0, '1);
            compare_word(1, "ext_req.valid in reset", 32'(ext_req.valid), 32'h0, '1);
            trc_start  = 0;
            trc_end    = 0;
            trc_in_run = 1'b0;
            text_cnt   = 0;
        end else begin
            if (exp_valid) begin
                exp_stall = !ext_ready;
            end else if (region == 4'hc && wr) begin
                exp_stall = (text_cnt < text_wait_cycles);
            end else begin
                exp_stall = 1'b0;
            end
            compare_word(1, "mem_stall", 32'(mem_stall), 32'(exp_stall), '1);
            compare_word(0, "ext_req.valid", 32'(ext_req.valid), 32'(exp_valid), '1);
            if (exp_valid) begin
                compare_word(0, "ext_req.addr", 32'(ext_req.addr), 32'({region, off}), '1);
                compare_word(0, "ext_req.wdata", ext_req.wdata, dmem_req.wdata, '1);
                compare_word(0, "ext_req write and byte_en",
                             32'({ext_req.write, ext_req.byte_en}),
                             32'({wr, dmem_req.byte_en}), '1);
                if (rd) begin
                    compare_word(0, "main memory read", dmem_rdata, ext_rdata, '1);
                end
            end
            if (region == 4'hf && rd) begin
                compare_word(0, "loader read", dmem_rdata, ldr_mem[lidx],
                             byte_mask(ldr_known[lidx]));
            end
            if ((region == 4'hb || region == 4'he) && rd) begin
                compare_word(0, "region b or e read", dmem_rdata, 32'h0, '1);
            end
            if (region == 4'hd && rd) begin
                if (off == mmio_pkg::TRACE_START_SEL) begin
                    compare_word(3, "trace start pointer", dmem_rdata, trc_start, '1);
                end else if (off == mmio_pkg::TRACE_END_SEL) begin
                    compare_word(3, "trace end pointer", dmem_rdata, trc_end, '1);
                end else begin
                    compare_word(3, "trace entry word", dmem_rdata, trc_mem[tidx][off[1:0]],
                                 {32{trc_known[tidx]}});
                end
            end
            if (instr_addr.region == 4'hf) begin
                compare_word(0, "loader fetch", instr_rdata, ldr_mem[iidx],
                             byte_mask(ldr_known[iidx]));
            end else begin
                compare_word(0, "fetch outside loader", instr_rdata, 32'h0, '1);
            end
            compare_word(2, "text_rd_char", 32'(text_rd_char), 32'(txt_mem[text_rd_addr]),
                         {32{txt_known[text_rd_addr]}});

            // one trace entry per stalled main memory cycle
            if (exp_valid && !ext_ready) begin
                trc_mem[trc_end][0] = dmem_req.wdata;
                trc_mem[trc_end][1] = {2'b00, region, off};
                trc_mem[trc_end][2] = {24'h0, dmem_req.byte_en, 2'b00, wr, rd && !wr};
                trc_mem[trc_end][3] = 32'h0;
                trc_known[trc_end]  = 1'b1;
                if (!trc_in_run) begin
                    trc_start = trc_end;
                end
                trc_end    = (trc_end + 1) % trc_depth;
                trc_in_run = 1'b1;
            end else begin
                trc_in_run = 1'b0;
            end

            if (region == 4'hf && wr && !mem_stall) begin
                for (i = 0; i < 4; i++) begin
                    if (dmem_req.byte_en[i]) begin
                        ldr_mem[lidx][8*i +: 8] = dmem_req.wdata[8*i +: 8];
                        ldr_known[lidx][i]      = 1'b1;
                    end
                end
            end

            if (region == 4'hc && wr) begin
                if (mem_stall) begin
                    text_cnt++;
                end else begin
                    // lane from the byte enable with non one-hot on lane 3
                    case (dmem_req.byte_en)
                        4'b1000: begin
                            lane = 2'd0;
                            chr  = dmem_req.wdata[7:0];
                        end
                        4'b0100: begin
                            lane = 2'd1;
                            chr  = dmem_req.wdata[15:8];
                        end
                        4'b0010: begin
                            lane = 2'd2;
                            chr  = dmem_req.wdata[23:16];
                        end
                        default: begin
                            lane = 2'd3;
                            chr  = dmem_req.wdata[31:24];
                        end
                    endcase
                    cidx            = (int'(off[12:0]) * 4 + int'(lane)) % txt_depth;
                    txt_mem[cidx]   = chr;
                    txt_known[cidx] = 1'b1;
                    text_cnt        = 0;
                end
            end else begin
                text_cnt = 0;
            end
        end
    end

endmodule

// File: verilog/mmio_top.sv
`timescale 1ns/1ns

module mmio_top #(
    parameter int loader_addr_bits = 10,
    parameter int text_addr_bits   = 15,
    parameter int text_wait_cycles = 5,
    parameter int trace_depth_bits = 6
) (
    input  logic                          clk_pipeline,
    input  logic                          rst,
    input  mmio_pkg::dmem_req_t           dmem_req,
    input  mmio_pkg::dmem_addr_t          instr_addr,
    output logic [mmio_pkg::WORD_W-1:0]   dmem_rdata,
    output logic [mmio_pkg::WORD_W-1:0]   instr_rdata,
    output logic                          mem_stall,
    output mmio_pkg::ext_req_t            ext_req,
    input  logic                          ext_ready,
    input  logic [mmio_pkg::WORD_W-1:0]   ext_rdata,
    input  logic [text_addr_bits-1:0]     text_rd_addr,
    output logic [7:0]                    text_rd_char
);

    logic [3:0]                     loader_we;
    mmio_pkg::text_req_t            text_req;
    logic                           ext_stall;
    logic [mmio_pkg::WORD_W-1:0]    loader_rdata;
    logic [mmio_pkg::WORD_W-1:0]    loader_instr;
    logic                           text_stall;
    logic [mmio_pkg::WORD_W-1:0]    trace_rdata;

    mmio_router u_router (
        .dmem_req     (dmem_req),
        .instr_addr   (instr_addr),
        .loader_rdata (loader_rdata),
        .loader_instr (loader_instr),
        .text_stall   (text_stall),
        .trace_rdata  (trace_rdata),
        .ext_ready    (ext_ready),
        .ext_rdata    (ext_rdata),
        .loader_we    (loader_we),
        .text_req     (text_req),
        .ext_req      (ext_req),
        .ext_stall    (ext_stall),
        .dmem_rdata   (dmem_rdata),
        .instr_rdata  (instr_rdata),
        .mem_stall    (mem_stall)
    );

    // low offset bits index the loader words directly
    loader_ram #(
        .loader_addr_bits (loader_addr_bits)
    ) u_loader (
        .clk_pipeline (clk_pipeline),
        .data_addr    (dmem_req.addr.offset[loader_addr_bits-1:0]),
        .we           (loader_we),
        .wdata        (dmem_req.wdata),
        .instr_addr   (instr_addr.offset[loader_addr_bits-1:0]),
        .rdata        (loader_rdata),
        .instr        (loader_instr)
    );

    text_write_port #(
        .text_addr_bits   (text_addr_bits),
        .text_wait_cycles (text_wait_cycles)
    ) u_text (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .text_req     (text_req),
        .text_rd_addr (text_rd_addr),
        .text_stall   (text_stall),
        .text_rd_char (text_rd_char)
    );

    trace_queue #(
        .trace_depth_bits (trace_depth_bits)
    ) u_trace (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .ext_req      (ext_req),
        .ext_stall    (ext_stall),
        .trace_sel    (dmem_req.addr.offset),
        .trace_rdata  (trace_rdata)
    );

endmodule

// File: verilog/trace_queue.sv
`timescale 1ns/1ns

module trace_queue #(
    parameter int trace_depth_bits = 6
) (
    input  logic                          clk_pipeline,
    input  logic                          rst,
    input  mmio_pkg::ext_req_t            ext_req,
    input  logic                          ext_stall,
    input  mmio_pkg::io_offset_u          trace_sel,
    output logic [mmio_pkg::WORD_W-1:0]   trace_rdata
);

    localparam int depth = 1 << trace_depth_bits;

    mmio_pkg::trace_entry_t         queue [0:depth-1];
    mmio_pkg::trace_entry_t         new_entry;
    logic [trace_depth_bits-1:0]    start_ptr;
    logic [trace_depth_bits-1:0]    end_ptr;
    logic                           in_run;
    logic [trace_depth_bits-1:0]    rd_idx;
    mmio_pkg::trace_entry_t         rd_entry;

    //////////////////////////////////////////////////////////////////////
    // recording
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        new_entry         = '0;
        new_entry.wdata   = ext_req.wdata;
        new_entry.addr    = ext_req.addr;
        new_entry.byte_en = ext_req.byte_en;
        new_entry.write   = ext_req.write;
        new_entry.read    = ext_req.valid & ~ext_req.write;
    end

    // one entry per stalled cycle, oldest ones get overwritten
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            start_ptr <= '0;
            end_ptr   <= '0;
            in_run    <= 1'b0;
        end else if (ext_stall) begin
            end_ptr <= end_ptr + 1'b1;
            in_run  <= 1'b1;
            // first cycle of a run marks where it begins
            if (!in_run) begin
                start_ptr <= end_ptr;
            end
        end else begin
            in_run <= 1'b0;
        end
    end

    always_ff @(posedge clk_pipeline) begin
        if (ext_stall) begin
            queue[end_ptr] <= new_entry;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // cpu read side
    //////////////////////////////////////////////////////////////////////

    assign rd_idx   = trace_depth_bits'(trace_sel.trace_view.entry);
    assign rd_entry = queue[rd_idx];

    always_comb begin
        if (trace_sel == mmio_pkg::TRACE_START_SEL) begin
            trace_rdata = {{(mmio_pkg::WORD_W-trace_depth_bits){1'b0}}, start_ptr};
        end else if (trace_sel == mmio_pkg::TRACE_END_SEL) begin
            trace_rdata = {{(mmio_pkg::WORD_W-trace_depth_bits){1'b0}}, end_ptr};
        end else begin
            trace_rdata = rd_entry[trace_sel.trace_view.word_sel*mmio_pkg::WORD_W +:
                                   mmio_pkg::WORD_W];
        end
    end

    a_end_moves_on_stall : assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        !ext_stall |=> $stable(end_ptr)
    ) else $error("trace end pointer moved outside a stall");

endmodule

// File: verilog/text_write_port.sv
`timescale 1ns/1ns

module text_write_port #(
    parameter int text_addr_bits   = 15,
    parameter int text_wait_cycles = 5
) (
    input  logic                        clk_pipeline,
    input  logic                        rst,
    input  mmio_pkg::text_req_t         text_req,
    input  logic [text_addr_bits-1:0]   text_rd_addr,
    output logic                        text_stall,
    output logic [7:0]                  text_rd_char
);

    localparam int depth = 1 << text_addr_bits;

    logic [7:0]                      char_mem [0:depth-1];
    logic [3:0]                      wait_cnt;
    logic                            wait_done;
    logic [1:0]                      lane;
    logic [7:0]                      char_data;
    logic [mmio_pkg::TEXT_WORD_W+1:0] full_addr;
    logic [text_addr_bits-1:0]       char_addr;

    //////////////////////////////////////////////////////////////////////
    // byte enable to lane and character
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (text_req.byte_en)
            4'b1000: begin
                lane      = 2'd0;
                char_data = text_req.wdata[7:0];
            end
            4'b0100: begin
                lane      = 2'd1;
                char_data = text_req.wdata[15:8];
            end
            4'b0010: begin
                lane      = 2'd2;
                char_data = text_req.wdata[23:16];
            end
            default: begin
                // 0001 and anything not one-hot
                lane      = 2'd3;
                char_data = text_req.wdata[31:24];
            end
        endcase
    end

    assign full_addr = {text_req.word_addr, lane};
    assign char_addr = text_addr_bits'(full_addr);

    //////////////////////////////////////////////////////////////////////
    // stall counter and write
    //////////////////////////////////////////////////////////////////////

    assign wait_done  = (wait_cnt == 4'(text_wait_cycles));
    assign text_stall = text_req.we & ~wait_done;

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wait_cnt <= 4'd0;
        end else if (text_req.we && !wait_done) begin
            wait_cnt <= wait_cnt + 4'd1;
        end else begin
            wait_cnt <= 4'd0;
        end
    end

    // character lands on the edge after the last stall cycle
    always_ff @(posedge clk_pipeline) begin
        if (text_req.we && wait_done) begin
            char_mem[char_addr] <= char_data;
        end
    end

    assign text_rd_char = char_mem[text_rd_addr];

    a_stall_len : assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        text_stall [*text_wait_cycles] |=> !text_stall
    ) else $error("text stall longer than %0d cycles", text_wait_cycles);

endmodule

// File: verilog/loader_ram.sv
`timescale 1ns/1ns

module loader_ram #(
    parameter int loader_addr_bits = 10
) (
    input  logic                          clk_pipeline,
    input  logic [loader_addr_bits-1:0]   data_addr,
    input  logic [3:0]                    we,
    input  logic [mmio_pkg::WORD_W-1:0]   wdata,
    input  logic [loader_addr_bits-1:0]   instr_addr,
    output logic [mmio_pkg::WORD_W-1:0]   rdata,
    output logic [mmio_pkg::WORD_W-1:0]   instr
);

    localparam int depth = 1 << loader_addr_bits;

    logic [mmio_pkg::WORD_W-1:0] mem [0:depth-1];

    // byte lane i covers bits 8i+7 down to 8i
    always_ff @(posedge clk_pipeline) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[data_addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // both ports read without a clock
    assign rdata = mem[data_addr];
    assign instr = mem[instr_addr];

endmodule

// File: verilog/mmio_router.sv
`timescale 1ns/1ns

module mmio_router (
    input  mmio_pkg::dmem_req_t               dmem_req,
    input  mmio_pkg::dmem_addr_t              instr_addr,
    input  logic [mmio_pkg::WORD_W-1:0]       loader_rdata,
    input  logic [mmio_pkg::WORD_W-1:0]       loader_instr,
    input  logic                              text_stall,
    input  logic [mmio_pkg::WORD_W-1:0]       trace_rdata,
    input  logic                              ext_ready,
    input  logic [mmio_pkg::WORD_W-1:0]       ext_rdata,
    output logic [3:0]                        loader_we,
    output mmio_pkg::text_req_t               text_req,
    output mmio_pkg::ext_req_t                ext_req,
    output logic                              ext_stall,
    output logic [mmio_pkg::WORD_W-1:0]       dmem_rdata,
    output logic [mmio_pkg::WORD_W-1:0]       instr_rdata,
    output logic                              mem_stall
);

    logic access;

    assign access = dmem_req.read | dmem_req.write;

    //////////////////////////////////////////////////////////////////////
    // data side decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // payload fans out to every device while only the strobes are steered
        loader_we          = 4'b0000;
        text_req.we        = 1'b0;
        text_req.word_addr = dmem_req.addr.offset.text_view.word;
        text_req.byte_en   = dmem_req.byte_en;
        text_req.wdata     = dmem_req.wdata;
        ext_req.valid      = 1'b0;
        ext_req.write      = 1'b0;
        ext_req.addr       = dmem_req.addr;
        ext_req.wdata      = dmem_req.wdata;
        ext_req.byte_en    = dmem_req.byte_en;
        dmem_rdata         = '0;

        case (dmem_req.addr.region)
            mmio_pkg::REGION_LOADER: begin
                loader_we  = {4{dmem_req.write}} & dmem_req.byte_en;
                dmem_rdata = loader_rdata;
            end
            mmio_pkg::REGION_TEXT: begin
                // write only so reads return zero
                text_req.we = dmem_req.write;
            end
            mmio_pkg::REGION_DEBUG: begin
                dmem_rdata = trace_rdata;
            end
            mmio_pkg::REGION_FLASH, mmio_pkg::REGION_KBD: begin
                dmem_rdata = '0;
            end
            default: begin
                // regions 0 to A are main memory
                ext_req.valid = access;
                ext_req.write = dmem_req.write;
                dmem_rdata    = ext_rdata;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // instruction side and stall combine
    //////////////////////////////////////////////////////////////////////

    assign instr_rdata = (instr_addr.region == mmio_pkg::REGION_LOADER) ? loader_instr : '0;

    assign ext_stall = ext_req.valid & ~ext_ready;
    assign mem_stall = ext_stall | text_stall;

endmodule

// File: verilog/mmio_pkg.sv
package mmio_pkg;

    parameter int WORD_W = 32;
    parameter int ADDR_W = 30;

    // character address is a text word address plus a 2-bit lane
    parameter int TEXT_WORD_W = 13;

    // full region offsets of the two trace pointer registers
    parameter logic [25:0] TRACE_START_SEL = 26'h3000001;
    parameter logic [25:0] TRACE_END_SEL   = 26'h3000002;

    // top nibble of the word address, other codes go to main memory
    typedef enum logic [3:0] {
        REGION_FLASH  = 4'hb,
        REGION_TEXT   = 4'hc,
        REGION_DEBUG  = 4'hd,
        REGION_KBD    = 4'he,
        REGION_LOADER = 4'hf
    } region_t;

    // region offset, read as a text address or as a trace selector
    typedef union packed {
        struct packed {
            logic [12:0]            upper;
            logic [TEXT_WORD_W-1:0] word;
        } text_view;
        struct packed {
            logic [17:0] upper;
            logic [5:0]  entry;
            logic [1:0]  word_sel;
        } trace_view;
    } io_offset_u;

    typedef struct packed {
        region_t    region;
        io_offset_u offset;
    } dmem_addr_t;

    typedef struct packed {
        logic              read;
        logic              write;
        dmem_addr_t        addr;
        logic [WORD_W-1:0] wdata;
        logic [3:0]        byte_en;
    } dmem_req_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic [3:0]        byte_en;
    } ext_req_t;

    // one character write toward the text memory
    typedef struct packed {
        logic                   we;
        logic [TEXT_WORD_W-1:0] word_addr;
        logic [3:0]             byte_en;
        logic [WORD_W-1:0]      wdata;
    } text_req_t;

    // four words, word 0 in the low bits
    typedef struct packed {
        logic [WORD_W-1:0]        word3_zero;
        logic [23:0]              word2_pad;
        logic [3:0]               byte_en;
        logic [1:0]               word2_rsvd;
        logic                     write;
        logic                     read;
        logic [WORD_W-ADDR_W-1:0] addr_pad;
        logic [ADDR_W-1:0]        addr;
        logic [WORD_W-1:0]        wdata;
    } trace_entry_t;

endpackage
